// ==== eth_afu_config.svh ====
//------------------------------
// Address map, constant read values and timing counts for the Ethernet AFU
// Include in any source that decodes registers or sizes the MAC bank
//------------------------------
`ifndef ETH_AFU_CONFIG_SVH
`define ETH_AFU_CONFIG_SVH

// 4-byte word addresses of the MMIO registers
`define ETH_AFU_ADDR_DFH     16'h0000
`define ETH_AFU_ADDR_ID_L    16'h0002
`define ETH_AFU_ADDR_ID_H    16'h0004
`define ETH_AFU_ADDR_INIT    16'h000A
`define ETH_AFU_ADDR_CTRL    16'h000C
`define ETH_AFU_ADDR_WDATA   16'h000E
`define ETH_AFU_ADDR_RDATA   16'h0010
`define ETH_AFU_ADDR_SCRATCH 16'h0012

// Feature header and AFU ID words
`define ETH_AFU_DFH_VALUE    64'h1000_0000_0000_0001
`define ETH_AFU_ID_L_VALUE   64'hB74F_291A_F34E_1783
`define ETH_AFU_ID_H_VALUE   64'h0518_9FE4_0676_DD24

// MAC bank size and timing
`define ETH_AFU_BANK_DEPTH   16
`define ETH_AFU_EXT_CAPTURE  3'd6
`define ETH_AFU_INIT_DELAY   20

`endif

// ==== eth_afu_pkg.sv ====
//------------------------------
// Shared types for the Ethernet AFU register block
// Referenced by scoped name from the decode, execute and top modules
//------------------------------
package eth_afu_pkg;

    //------------------------------
    // Register select
    //------------------------------
    // One value per mapped register, CSR_NONE on a miss
    typedef enum logic [3:0]
    {
        CSR_NONE,
        CSR_DFH,
        CSR_ID_L,
        CSR_ID_H,
        CSR_INIT,
        CSR_CTRL,
        CSR_WDATA,
        CSR_RDATA,
        CSR_SCRATCH
    } csr_sel_e;

    //------------------------------
    // MMIO data word
    //------------------------------
    // Raw 64-bit view, or the MAC command view of the same word
    typedef union packed
    {
        logic [63:0] raw;
        struct packed
        {
            // Upper bits carry nothing for the MAC
            logic [45:0] rsvd;
            // Read and write command strobes
            logic        rd_cmd;
            logic        wr_cmd;
            // Register address inside the MAC bank
            logic [15:0] bank_addr;
        } cmd;
    } mmio_word_u;

endpackage

// ==== mmio_decode.sv ====
//------------------------------
// MMIO request stage: registers the host strobes into T1
// and turns the word address into a register select
//------------------------------
`timescale 1ns/100ps
`include "eth_afu_config.svh"

module mmio_decode
(
    input  logic                  pClk,
    input  logic                  pck_cp2af_softReset_T1,
    input  logic                  mmio_wr_valid,
    input  logic                  mmio_rd_valid,
    input  logic [15:0]           mmio_addr,
    input  logic [8:0]            mmio_tid,
    input  logic [63:0]           mmio_wr_data,
    output eth_afu_pkg::csr_sel_e sel,
    output logic                  wr_en,
    output logic                  rd_en,
    output logic [8:0]            tid,
    output logic [63:0]           wr_data
);

    // Select decoded from the raw pins, captured at T1
    eth_afu_pkg::csr_sel_e sel_next;

    //------------------------------
    // Address decode
    //------------------------------
    // Full 16-bit compare, so odd or high addresses fall to CSR_NONE
    always_comb
    begin
        case (mmio_addr)
            `ETH_AFU_ADDR_DFH:     sel_next = eth_afu_pkg::CSR_DFH;
            `ETH_AFU_ADDR_ID_L:    sel_next = eth_afu_pkg::CSR_ID_L;
            `ETH_AFU_ADDR_ID_H:    sel_next = eth_afu_pkg::CSR_ID_H;
            `ETH_AFU_ADDR_INIT:    sel_next = eth_afu_pkg::CSR_INIT;
            `ETH_AFU_ADDR_CTRL:    sel_next = eth_afu_pkg::CSR_CTRL;
            `ETH_AFU_ADDR_WDATA:   sel_next = eth_afu_pkg::CSR_WDATA;
            `ETH_AFU_ADDR_RDATA:   sel_next = eth_afu_pkg::CSR_RDATA;
            `ETH_AFU_ADDR_SCRATCH: sel_next = eth_afu_pkg::CSR_SCRATCH;
            default:               sel_next = eth_afu_pkg::CSR_NONE;
        endcase
    end

    //------------------------------
    // T1 stage
    //------------------------------
    // Strobes and select
    always_ff @(posedge pClk or posedge pck_cp2af_softReset_T1)
    begin
        if (pck_cp2af_softReset_T1)
        begin
            sel   <= eth_afu_pkg::CSR_NONE;
            wr_en <= 1'b0;
            rd_en <= 1'b0;
        end
        else
        begin
            sel   <= sel_next;
            wr_en <= mmio_wr_valid;
            rd_en <= mmio_rd_valid;
        end
    end

    // Tag and write payload ride alongside
    always_ff @(posedge pClk)
    begin
        tid     <= mmio_tid;
        wr_data <= mmio_wr_data;
    end

    // Host never issues a write and a read together
    a_no_wr_rd_overlap: assert property (@(posedge pClk) disable iff (pck_cp2af_softReset_T1)
        !(mmio_wr_valid && mmio_rd_valid));

endmodule

// ==== csr_execute.sv ====
//------------------------------
// Register file of the AFU: stores host writes, drives the MAC bank
// commands with self-clearing bits, and returns the registered read mux
//------------------------------
`timescale 1ns/100ps
`include "eth_afu_config.svh"

module csr_execute
(
    input  logic                  pClk,
    input  logic                  pck_cp2af_softReset_T1,
    input  eth_afu_pkg::csr_sel_e sel,
    input  logic                  wr_en,
    input  logic [63:0]           wr_data,
    input  logic [31:0]           eth_rd_data,
    input  logic                  init_done,
    output logic [63:0]           rd_data,
    output logic [31:0]           eth_ctrl_addr,
    output logic [31:0]           eth_wr_data,
    output logic                  init_start
);

    //------------------------------
    // Stored registers
    //------------------------------
    logic [63:0]            afu_init;
    eth_afu_pkg::mmio_word_u cmd_reg;
    logic [31:0]            wdata_reg;
    logic [31:0]            rdata_reg;
    logic [63:0]            scratch_reg;
    // Pulse extenders for the two command bits
    logic [2:0]             wr_extend;
    logic [2:0]             rd_extend;
    // init_done as seen by the CSR side
    logic                   init_done_r;

    // Host writes, then the extenders clear the command bits
    always_ff @(posedge pClk or posedge pck_cp2af_softReset_T1)
    begin
        if (pck_cp2af_softReset_T1)
        begin
            afu_init    <= '0;
            cmd_reg     <= '0;
            wdata_reg   <= '0;
            scratch_reg <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                case (sel)
                    eth_afu_pkg::CSR_INIT:    afu_init    <= wr_data;
                    eth_afu_pkg::CSR_CTRL:    cmd_reg.raw <= {32'b0, wr_data[31:0]};
                    eth_afu_pkg::CSR_WDATA:   wdata_reg   <= wr_data[31:0];
                    eth_afu_pkg::CSR_SCRATCH: scratch_reg <= wr_data;
                    // DFH, IDs and read data are read only
                    default: ;
                endcase
            end
            // Self clear once the extender wraps
            if (&wr_extend)
                cmd_reg.cmd.wr_cmd <= 1'b0;
            if (&rd_extend)
                cmd_reg.cmd.rd_cmd <= 1'b0;
        end
    end

    //------------------------------
    // Extenders and MAC side copies
    //------------------------------
    always_ff @(posedge pClk or posedge pck_cp2af_softReset_T1)
    begin
        if (pck_cp2af_softReset_T1)
        begin
            wr_extend     <= '0;
            rd_extend     <= '0;
            eth_ctrl_addr <= '0;
            init_start    <= 1'b0;
            init_done_r   <= 1'b0;
            rdata_reg     <= '0;
        end
        else
        begin
            // Count only while the command bit is set
            wr_extend     <= wr_extend + 3'(cmd_reg.cmd.wr_cmd);
            rd_extend     <= rd_extend + 3'(cmd_reg.cmd.rd_cmd);
            eth_ctrl_addr <= cmd_reg.raw[31:0];
            init_start    <= afu_init[0];
            init_done_r   <= init_done;
            // Bank read data has settled by this count
            if (rd_extend == `ETH_AFU_EXT_CAPTURE)
                rdata_reg <= eth_rd_data;
        end
    end

    // Write data for the bank
    always_ff @(posedge pClk)
    begin
        eth_wr_data <= wdata_reg;
    end

    //------------------------------
    // Read mux, valid at T2
    //------------------------------
    always_ff @(posedge pClk)
    begin
        case (sel)
            eth_afu_pkg::CSR_DFH:     rd_data <= `ETH_AFU_DFH_VALUE;
            eth_afu_pkg::CSR_ID_L:    rd_data <= `ETH_AFU_ID_L_VALUE;
            eth_afu_pkg::CSR_ID_H:    rd_data <= `ETH_AFU_ID_H_VALUE;
            // Bit 1 reports init done
            eth_afu_pkg::CSR_INIT:    rd_data <= {afu_init[63:2], init_done_r, afu_init[0]};
            eth_afu_pkg::CSR_CTRL:    rd_data <= cmd_reg.raw;
            eth_afu_pkg::CSR_WDATA:   rd_data <= {32'b0, wdata_reg};
            eth_afu_pkg::CSR_RDATA:   rd_data <= {32'b0, rdata_reg};
            eth_afu_pkg::CSR_SCRATCH: rd_data <= scratch_reg;
            default:                  rd_data <= '0;
        endcase
    end

    // A command bit never sticks past its extender window
    a_wr_cmd_clears: assert property (@(posedge pClk) disable iff (pck_cp2af_softReset_T1)
        $rose(cmd_reg.cmd.wr_cmd) |-> ##[1:8] !cmd_reg.cmd.wr_cmd);
    a_rd_cmd_clears: assert property (@(posedge pClk) disable iff (pck_cp2af_softReset_T1)
        $rose(cmd_reg.cmd.rd_cmd) |-> ##[1:8] !cmd_reg.cmd.rd_cmd);

endmodule

// ==== mmio_result.sv ====
//------------------------------
// MMIO response stage: carries tag and valid beside the read data
// and presents the response at T3
//------------------------------
`timescale 1ns/100ps

module mmio_result
(
    input  logic        pClk,
    input  logic        pck_cp2af_softReset_T1,
    input  logic        rd_en,
    input  logic [8:0]  tid,
    input  logic [63:0] rd_data,
    output logic        mmio_rsp_valid,
    output logic [8:0]  mmio_rsp_tid,
    output logic [63:0] mmio_rsp_data
);

    // T2 copies, aligned with the registered read mux
    logic       rd_en_t2;
    logic [8:0] tid_t2;

    // Valid pipe
    always_ff @(posedge pClk or posedge pck_cp2af_softReset_T1)
    begin
        if (pck_cp2af_softReset_T1)
        begin
            rd_en_t2       <= 1'b0;
            mmio_rsp_valid <= 1'b0;
        end
        else
        begin
            rd_en_t2       <= rd_en;
            mmio_rsp_valid <= rd_en_t2;
        end
    end

    // Tag and data pipe, one read per stage
    always_ff @(posedge pClk)
    begin
        tid_t2        <= tid;
        mmio_rsp_tid  <= tid_t2;
        mmio_rsp_data <= rd_data;
    end

    // Every response traces back to a read strobe
    a_rsp_follows_rd: assert property (@(posedge pClk) disable iff (pck_cp2af_softReset_T1)
        mmio_rsp_valid |-> $past(rd_en, 2));

endmodule

// ==== eth_reg_bank.sv ====
//------------------------------
// Model of the MAC register side: acts on command bit edges
// and reports init done a fixed delay after init start
//------------------------------
`timescale 1ns/100ps
`include "eth_afu_config.svh"

module eth_reg_bank
(
    input  logic        pClk,
    input  logic        pck_cp2af_softReset_T1,
    input  logic [31:0] eth_ctrl_addr,
    input  logic [31:0] eth_wr_data,
    input  logic        init_start,
    output logic [31:0] eth_rd_data,
    output logic        init_done
);

    localparam int unsigned ADDR_W = $clog2(`ETH_AFU_BANK_DEPTH);
    localparam int unsigned CNT_W  = $clog2(`ETH_AFU_INIT_DELAY);

    // MAC registers
    logic [31:0]      bank [`ETH_AFU_BANK_DEPTH];
    // Previous command and init levels for edge detect
    logic             wr_cmd_q;
    logic             rd_cmd_q;
    logic             init_start_q;
    // Init sequence
    logic             init_busy;
    logic [CNT_W-1:0] init_cnt;

    logic wr_rise;
    logic rd_rise;
    logic init_rise;

    assign wr_rise   = eth_ctrl_addr[16] & ~wr_cmd_q;
    assign rd_rise   = eth_ctrl_addr[17] & ~rd_cmd_q;
    assign init_rise = init_start & ~init_start_q;

    //------------------------------
    // Edge detect and init timer
    //------------------------------
    always_ff @(posedge pClk or posedge pck_cp2af_softReset_T1)
    begin
        if (pck_cp2af_softReset_T1)
        begin
            wr_cmd_q     <= 1'b0;
            rd_cmd_q     <= 1'b0;
            init_start_q <= 1'b0;
            init_busy    <= 1'b0;
            init_cnt     <= '0;
            init_done    <= 1'b0;
        end
        else
        begin
            wr_cmd_q     <= eth_ctrl_addr[16];
            rd_cmd_q     <= eth_ctrl_addr[17];
            init_start_q <= init_start;
            // A new start restarts the sequence
            if (init_rise)
            begin
                init_done <= 1'b0;
                init_busy <= 1'b1;
                init_cnt  <= '0;
            end
            else if (init_busy)
            begin
                if (init_cnt == CNT_W'(`ETH_AFU_INIT_DELAY - 1))
                begin
                    init_done <= 1'b1;
                    init_busy <= 1'b0;
                end
                else
                    init_cnt <= init_cnt + 1'b1;
            end
        end
    end

    // Bank access on command edges
    always_ff @(posedge pClk)
    begin
        if (wr_rise)
            bank[eth_ctrl_addr[ADDR_W-1:0]] <= eth_wr_data;
        if (rd_rise)
            eth_rd_data <= bank[eth_ctrl_addr[ADDR_W-1:0]];
    end

endmodule

// ==== eth_afu_top.sv ====
//------------------------------
// Ethernet AFU control block: MMIO decode, CSR execute,
// response pipe and the MAC register bank on one clock
//------------------------------
`timescale 1ns/100ps

module eth_afu_top
(
    input  logic        pClk,
    input  logic        pck_cp2af_softReset_T1,
    // Host MMIO requests
    input  logic        mmio_wr_valid,
    input  logic        mmio_rd_valid,
    input  logic [15:0] mmio_addr,
    input  logic [8:0]  mmio_tid,
    input  logic [63:0] mmio_wr_data,
    // Host MMIO read response
    output logic        mmio_rsp_valid,
    output logic [8:0]  mmio_rsp_tid,
    output logic [63:0] mmio_rsp_data
);

    //------------------------------
    // T1 request
    //------------------------------
    eth_afu_pkg::csr_sel_e sel;
    logic                  wr_en;
    logic                  rd_en;
    logic [8:0]            tid;
    logic [63:0]           wr_data;

    // T2 read data
    logic [63:0] rd_data;

    // MAC side
    logic [31:0] eth_ctrl_addr;
    logic [31:0] eth_wr_data;
    logic [31:0] eth_rd_data;
    logic        init_start;
    logic        init_done;

    mmio_decode u_mmio_decode
    (
        .pClk                   (pClk),
        .pck_cp2af_softReset_T1 (pck_cp2af_softReset_T1),
        .mmio_wr_valid          (mmio_wr_valid),
        .mmio_rd_valid          (mmio_rd_valid),
        .mmio_addr              (mmio_addr),
        .mmio_tid               (mmio_tid),
        .mmio_wr_data           (mmio_wr_data),
        .sel                    (sel),
        .wr_en                  (wr_en),
        .rd_en                  (rd_en),
        .tid                    (tid),
        .wr_data                (wr_data)
    );

    csr_execute u_csr_execute
    (
        .pClk                   (pClk),
        .pck_cp2af_softReset_T1 (pck_cp2af_softReset_T1),
        .sel                    (sel),
        .wr_en                  (wr_en),
        .wr_data                (wr_data),
        .eth_rd_data            (eth_rd_data),
        .init_done              (init_done),
        .rd_data                (rd_data),
        .eth_ctrl_addr          (eth_ctrl_addr),
        .eth_wr_data            (eth_wr_data),
        .init_start             (init_start)
    );

    mmio_result u_mmio_result
    (
        .pClk                   (pClk),
        .pck_cp2af_softReset_T1 (pck_cp2af_softReset_T1),
        .rd_en                  (rd_en),
        .tid                    (tid),
        .rd_data                (rd_data),
        .mmio_rsp_valid         (mmio_rsp_valid),
        .mmio_rsp_tid           (mmio_rsp_tid),
        .mmio_rsp_data          (mmio_rsp_data)
    );

    // Stand-in for the MAC register interface
    eth_reg_bank u_eth_reg_bank
    (
        .pClk                   (pClk),
        .pck_cp2af_softReset_T1 (pck_cp2af_softReset_T1),
        .eth_ctrl_addr          (eth_ctrl_addr),
        .eth_wr_data            (eth_wr_data),
        .init_start             (init_start),
        .eth_rd_data            (eth_rd_data),
        .init_done              (init_done)
    );

endmodule

// ==== tb_eth_afu.sv ====
//------------------------------
// Testbench for the Ethernet AFU control block
// Drives MMIO writes and reads, concurrent assertions check every response
//------------------------------
`timescale 1ns/100ps
`include "eth_afu_config.svh"

module tb_eth_afu;

    localparam int RSP_TIMEOUT = 20;
    localparam int INIT_POLLS  = 20;
    // Command bits in the command-address word
    localparam logic [63:0] WR_CMD = 64'h1_0000;
    localparam logic [63:0] RD_CMD = 64'h2_0000;

    logic        pClk;
    logic        pck_cp2af_softReset_T1;
    logic        mmio_wr_valid;
    logic        mmio_rd_valid;
    logic [15:0] mmio_addr;
    logic [8:0]  mmio_tid;
    logic [63:0] mmio_wr_data;
    logic        mmio_rsp_valid;
    logic [8:0]  mmio_rsp_tid;
    logic [63:0] mmio_rsp_data;
    // Expected response, driven beside each read request
    logic [63:0] exp_data;
    logic [63:0] exp_mask;
    logic [63:0] last_rsp;
    int          err_cnt = 0;
    int          err_base = 0;
    int          test_cnt = 0;
    int          test_fail_cnt = 0;
    int          rd_cnt = 0;
    int          rsp_cnt = 0;

    eth_afu_top dut
    (
        .pClk                   (pClk),
        .pck_cp2af_softReset_T1 (pck_cp2af_softReset_T1),
        .mmio_wr_valid          (mmio_wr_valid),
        .mmio_rd_valid          (mmio_rd_valid),
        .mmio_addr              (mmio_addr),
        .mmio_tid               (mmio_tid),
        .mmio_wr_data           (mmio_wr_data),
        .mmio_rsp_valid         (mmio_rsp_valid),
        .mmio_rsp_tid           (mmio_rsp_tid),
        .mmio_rsp_data          (mmio_rsp_data)
    );

    always #5 pClk = ~pClk;

    // Count responses away from the drive edge
    always @(negedge pClk)
    begin
        if (mmio_rsp_valid)
        begin
            rsp_cnt++;
            last_rsp = mmio_rsp_data;
        end
    end

    //------------------------------
    // Response checks
    //------------------------------
    a_rsp_latency: assert property (@(posedge pClk) disable iff (pck_cp2af_softReset_T1)
        $past(mmio_rd_valid, 3) == mmio_rsp_valid)
    else
    begin
        err_cnt++;
        $display("ERROR: %0d ns: response valid not 3 cycles after its read", $time);
    end

    a_rsp_tag: assert property (@(posedge pClk) disable iff (pck_cp2af_softReset_T1)
        mmio_rsp_valid |-> mmio_rsp_tid == $past(mmio_tid, 3))
    else
    begin
        err_cnt++;
        $display("ERROR: %0d ns: tag %h, expected %h", $time,
            $sampled(mmio_rsp_tid), $past(mmio_tid, 3));
    end

    a_rsp_data: assert property (@(posedge pClk) disable iff (pck_cp2af_softReset_T1)
        mmio_rsp_valid |-> (mmio_rsp_data & $past(exp_mask, 3)) == $past(exp_data, 3))
    else
    begin
        err_cnt++;
        $display("ERROR: %0d ns: read data %h, expected %h", $time,
            $sampled(mmio_rsp_data), $past(exp_data, 3));
    end

    //------------------------------
    // MMIO tasks
    //------------------------------
    task automatic mmio_write(input logic [15:0] addr, input logic [63:0] data);
        @(posedge pClk);
        mmio_wr_valid <= 1'b1;
        mmio_addr     <= addr;
        mmio_wr_data  <= data;
        @(posedge pClk);
        mmio_wr_valid <= 1'b0;
    endtask

    // One read cycle with a random tag, no wait
    task automatic issue_read(input logic [15:0] addr, input logic [63:0] expected,
                              input logic [63:0] mask);
        @(posedge pClk);
        mmio_rd_valid <= 1'b1;
        mmio_addr     <= addr;
        mmio_tid      <= 9'($urandom);
        exp_data      <= expected & mask;
        exp_mask      <= mask;
        rd_cnt++;
    endtask

    // Drop the read strobe, then wait until every read is answered
    task automatic wait_responses;
        int cycles;
        cycles = 0;
        @(posedge pClk);
        mmio_rd_valid <= 1'b0;
        while (rsp_cnt < rd_cnt && cycles < RSP_TIMEOUT)
        begin
            @(posedge pClk);
            cycles++;
        end
        if (rsp_cnt < rd_cnt)
        begin
            $display("Timeout: only %0d of %0d read responses arrived", rsp_cnt, rd_cnt);
            $display("Simulation failed");
            $finish;
        end
    endtask

    task automatic mmio_read(input logic [15:0] addr, input logic [63:0] expected,
                             input logic [63:0] mask);
        issue_read(addr, expected, mask);
        wait_responses();
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        if (err_cnt == err_base)
            $display("test %0d %s: ok", test_cnt, name);
        else
        begin
            test_fail_cnt++;
            $display("test %0d %s: FAILED, %0d errors", test_cnt, name, err_cnt - err_base);
        end
        err_base = err_cnt;
    endtask

    //------------------------------
    // Stimulus
    //------------------------------
    initial
    begin
        logic [63:0] val [4];
        logic [63:0] a [4];
        logic [63:0] r;
        logic [15:0] bank_addr;
        int          polls;
        void'($urandom(62));
        pClk = 1'b0;
        pck_cp2af_softReset_T1 = 1'b1;
        mmio_wr_valid = 1'b0;
        mmio_rd_valid = 1'b0;
        mmio_addr = '0;
        mmio_tid = '0;
        mmio_wr_data = '0;
        exp_data = '0;
        exp_mask = '0;
        repeat (8) @(posedge pClk);
        pck_cp2af_softReset_T1 <= 1'b0;
        repeat (2) @(posedge pClk);

        // Constants, zeroed registers and misses
        mmio_read(`ETH_AFU_ADDR_DFH, `ETH_AFU_DFH_VALUE, '1);
        mmio_read(`ETH_AFU_ADDR_ID_L, `ETH_AFU_ID_L_VALUE, '1);
        mmio_read(`ETH_AFU_ADDR_ID_H, `ETH_AFU_ID_H_VALUE, '1);
        mmio_read(`ETH_AFU_ADDR_INIT, 64'h0, '1);
        mmio_read(`ETH_AFU_ADDR_CTRL, 64'h0, '1);
        mmio_read(`ETH_AFU_ADDR_WDATA, 64'h0, '1);
        mmio_read(`ETH_AFU_ADDR_RDATA, 64'h0, '1);
        mmio_read(`ETH_AFU_ADDR_SCRATCH, 64'h0, '1);
        mmio_read(16'h0001, 64'h0, '1);
        mmio_read(16'h0014, 64'h0, '1);
        mmio_read(16'h0102, 64'h0, '1);
        finish_test("reset and constants");

        // Scratch keeps all 64 bits, ID words ignore writes
        for (int i = 0; i < 3; i++)
        begin
            r = {$urandom, $urandom};
            mmio_write(`ETH_AFU_ADDR_SCRATCH, r);
            mmio_read(`ETH_AFU_ADDR_SCRATCH, r, '1);
        end
        mmio_write(`ETH_AFU_ADDR_ID_L, {$urandom, $urandom});
        mmio_write(`ETH_AFU_ADDR_ID_H, {$urandom, $urandom});
        mmio_read(`ETH_AFU_ADDR_ID_L, `ETH_AFU_ID_L_VALUE, '1);
        mmio_read(`ETH_AFU_ADDR_ID_H, `ETH_AFU_ID_H_VALUE, '1);
        finish_test("scratch");

        // Four reads back to back, answered in order
        issue_read(`ETH_AFU_ADDR_DFH, `ETH_AFU_DFH_VALUE, '1);
        issue_read(`ETH_AFU_ADDR_SCRATCH, r, '1);
        issue_read(`ETH_AFU_ADDR_ID_H, `ETH_AFU_ID_H_VALUE, '1);
        issue_read(`ETH_AFU_ADDR_ID_L, `ETH_AFU_ID_L_VALUE, '1);
        wait_responses();
        finish_test("pipelined reads");

        // Bank writes to four distinct addresses, then read each back
        bank_addr = 16'($urandom_range(0, 15));
        for (int i = 0; i < 4; i++)
        begin
            a[i] = 64'((bank_addr + 5 * i) & 16'hF);
            val[i] = {$urandom, $urandom};
            mmio_write(`ETH_AFU_ADDR_WDATA, val[i]);
            mmio_write(`ETH_AFU_ADDR_CTRL, WR_CMD | a[i]);
            repeat (10) @(posedge pClk);
        end
        for (int i = 0; i < 4; i++)
        begin
            mmio_write(`ETH_AFU_ADDR_CTRL, RD_CMD | a[i]);
            repeat (10) @(posedge pClk);
            mmio_read(`ETH_AFU_ADDR_RDATA, {32'b0, val[i][31:0]}, '1);
        end
        finish_test("ethernet transfer");

        // Both command bits clear, the full 16-bit address stays
        bank_addr = 16'($urandom);
        mmio_write(`ETH_AFU_ADDR_CTRL, WR_CMD | 64'(bank_addr));
        repeat (10) @(posedge pClk);
        mmio_read(`ETH_AFU_ADDR_CTRL, 64'(bank_addr), '1);
        mmio_write(`ETH_AFU_ADDR_CTRL, RD_CMD | 64'(bank_addr));
        repeat (10) @(posedge pClk);
        mmio_read(`ETH_AFU_ADDR_CTRL, 64'(bank_addr), '1);
        finish_test("command self clear");

        // Init start, done bit low at first, then poll it high
        mmio_write(`ETH_AFU_ADDR_INIT, 64'h1);
        mmio_read(`ETH_AFU_ADDR_INIT, 64'h1, '1);
        polls = 0;
        last_rsp = '0;
        while (!last_rsp[1] && polls < INIT_POLLS)
        begin
            mmio_read(`ETH_AFU_ADDR_INIT, 64'h1, ~64'h2);
            polls++;
        end
        if (!last_rsp[1])
        begin
            err_cnt++;
            $display("Init done bit never read back as one after %0d polls", polls);
        end
        finish_test("init sequence");

        $display("tests: %0d run, %0d failed, %0d errors", test_cnt, test_fail_cnt, err_cnt);
        if (err_cnt == 0 && test_fail_cnt == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
eth_afu_pkg.sv
mmio_decode.sv
csr_execute.sv
mmio_result.sv
eth_reg_bank.sv
eth_afu_top.sv
tb_eth_afu.sv

// ==== Bender.yml ====
package:
  name: eth_afu

sources:
  - include_dirs:
      - .
    files:
      - eth_afu_pkg.sv
      - mmio_decode.sv
      - csr_execute.sv
      - mmio_result.sv
      - eth_reg_bank.sv
      - eth_afu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_eth_afu.sv
